// File: Makefile
# Verilator build and run for the UART peripheral testbench
# Override any variable on the command line, e.g. make run SIM_ARGS=...

VERILATOR ?= verilator
TOP       ?= uart_periph_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= V$(TOP)
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(SIM_BIN)

# Output is shown and then searched for the pass line; no match fails the target
run: compile
	@out="$$(./$(OBJ_DIR)/$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_console_tap.sv
source/uart_reg_if.sv
source/uart_periph.sv
verif/uart_periph_assertions.sv
verif/uart_periph_tb.sv

// File: source/uart_baud_gen.sv
// Baud tick generator for both serial engines
// os_tick_o pulses sixteen times per bit, bit_tick_o once per bit
`timescale 1ns/1ps

module uart_baud_gen #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic sysclk_i,
  input  logic rst_n_i,
  output logic bit_tick_o,
  output logic os_tick_o
);

  // Cycles per oversample tick, at least one
  localparam int OS_DIV = CLKS_PER_BIT / 16;
  localparam int OS_W   = (OS_DIV > 1) ? $clog2(OS_DIV) : 1;

  logic [OS_W-1:0] os_cnt;
  logic [3:0]      os_phase;
  logic            os_wrap;

  assign os_wrap = (os_cnt == OS_W'(OS_DIV - 1));

  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      os_cnt     <= '0;
      os_phase   <= '0;
      os_tick_o  <= 1'b0;
      bit_tick_o <= 1'b0;
    end else begin
      os_tick_o  <= os_wrap;
      // Every sixteenth oversample tick closes a bit period
      bit_tick_o <= os_wrap && (os_phase == 4'd15);
      if (os_wrap) begin
        os_cnt   <= '0;
        os_phase <= os_phase + 4'd1;
      end else begin
        os_cnt <= os_cnt + 1'b1;
      end
    end
  end

endmodule

// File: source/uart_console_tap.sv
// Console tap between the register interface and the two FIFOs
// Mirrors each TX FIFO write to the console ports in the same cycle
// Owns the RX FIFO write port; console injection wins over a line byte
`timescale 1ns/1ps

module uart_console_tap (
  input  logic             tx_push_i,
  input  uart_pkg::byte_t  tx_data_i,
  output logic             tx_push_o,
  output uart_pkg::byte_t  tx_data_o,
  output logic             con_tx_wr_o,
  output uart_pkg::byte_t  con_tx_data_o,
  input  uart_pkg::rx_wr_t line_byte_i,
  input  logic             con_rx_wr_i,
  input  uart_pkg::byte_t  con_rx_data_i,
  input  logic             rx_full_i,
  output uart_pkg::rx_wr_t rx_wr_o,
  output logic             con_rx_full_o,
  output logic             line_drop_o
);

  logic inject_ok;

  // Transmit path goes through untouched, the console sees a copy
  assign tx_push_o     = tx_push_i;
  assign tx_data_o     = tx_data_i;
  assign con_tx_wr_o   = tx_push_i;
  // Console data is zero whenever there is no strobe
  assign con_tx_data_o = tx_push_i ? tx_data_i : '0;

  // Only this block looks at fullness, so the FIFO never sees a write while full
  assign inject_ok     = con_rx_wr_i && !rx_full_i;
  assign rx_wr_o.valid = inject_ok || (line_byte_i.valid && !rx_full_i);
  assign rx_wr_o.data  = inject_ok ? con_rx_data_i : line_byte_i.data;

  // A line byte loses to injection or to a full FIFO, and is reported as overrun
  assign line_drop_o   = line_byte_i.valid && (inject_ok || rx_full_i);
  assign con_rx_full_o = rx_full_i;

endmodule

// File: source/uart_fifo.sv
// Synchronous byte FIFO used for both the transmit and the receive path
// The head entry is always visible on rdata_o, a read just advances past it
// Callers must not write while full_o or read while empty_o
`timescale 1ns/1ps

module uart_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              sysclk_i,
  input  logic              rst_n_i,
  input  logic              wr_i,
  input  uart_pkg::byte_t   wdata_i,
  input  logic              rd_i,
  output uart_pkg::byte_t   rdata_o,
  output logic              full_o,
  output logic              empty_o
);

  // Index width; pointers carry one extra wrap bit
  localparam int AW = $clog2(FIFO_DEPTH);

  uart_pkg::byte_t mem [FIFO_DEPTH];
  logic [AW:0]     wr_ptr;
  logic [AW:0]     rd_ptr;

  // ==============================
  // Storage
  // ==============================

  // Payload storage only, pointers decide what is valid
  always_ff @(posedge sysclk_i) begin
    if (wr_i) begin
      mem[wr_ptr[AW-1:0]] <= wdata_i;
    end
  end

  assign rdata_o = mem[rd_ptr[AW-1:0]];

  // ==============================
  // Pointers and levels
  // ==============================

  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Same index with different wrap bits means the buffer has gone round once
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

// File: source/uart_periph.sv
// UART peripheral top level with a console tap
// Strobe bus in, 8N1 serial line out, console mirror and injection ports
// CLKS_PER_BIT must be a multiple of 16, FIFO_DEPTH a power of two
`timescale 1ns/1ps

module uart_periph #(
  parameter int CLKS_PER_BIT = 16,
  parameter int FIFO_DEPTH   = 8
) (
  input  logic                sysclk_i,
  input  logic                rst_n_i,
  // Bus
  input  logic                bus_wr_i,
  input  logic                bus_rd_i,
  input  uart_pkg::reg_addr_t bus_addr_i,
  input  uart_pkg::byte_t     bus_wdata_i,
  output uart_pkg::byte_t     bus_rdata_o,
  // Serial line
  output logic                txd_o,
  input  logic                rxd_i,
  // Console
  output logic                con_tx_wr_o,
  output uart_pkg::byte_t     con_tx_data_o,
  input  logic                con_rx_wr_i,
  input  uart_pkg::byte_t     con_rx_data_i,
  output logic                con_rx_full_o
);

  logic             rif_tx_push;
  uart_pkg::byte_t  rif_tx_data;
  logic             tx_push;
  uart_pkg::byte_t  tx_data;
  uart_pkg::byte_t  tx_head;
  logic             tx_full;
  logic             tx_empty;
  logic             tx_pop;
  logic             tx_idle;
  logic             rx_pop;
  uart_pkg::byte_t  rx_head;
  logic             rx_full;
  logic             rx_empty;
  uart_pkg::rx_wr_t line_byte;
  uart_pkg::rx_wr_t rx_wr;
  logic             line_drop;
  logic             bit_tick;
  logic             os_tick;

  // ==============================
  // Bus side and console tap
  // ==============================

  uart_reg_if reg_if_i (
    .sysclk_i, .rst_n_i, .bus_wr_i, .bus_rd_i, .bus_addr_i, .bus_wdata_i, .bus_rdata_o,
    .tx_push_o(rif_tx_push), .tx_data_o(rif_tx_data), .tx_full_i(tx_full),
    .tx_idle_i(tx_idle), .rx_pop_o(rx_pop), .rx_data_i(rx_head), .rx_full_i(rx_full),
    .rx_empty_i(rx_empty), .line_drop_i(line_drop)
  );

  uart_console_tap tap_i (
    .tx_push_i(rif_tx_push), .tx_data_i(rif_tx_data), .tx_push_o(tx_push),
    .tx_data_o(tx_data), .con_tx_wr_o, .con_tx_data_o, .line_byte_i(line_byte),
    .con_rx_wr_i, .con_rx_data_i, .rx_full_i(rx_full), .rx_wr_o(rx_wr),
    .con_rx_full_o, .line_drop_o(line_drop)
  );

  // ==============================
  // FIFOs
  // ==============================

  uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
    .sysclk_i, .rst_n_i, .wr_i(tx_push), .wdata_i(tx_data), .rd_i(tx_pop),
    .rdata_o(tx_head), .full_o(tx_full), .empty_o(tx_empty)
  );

  uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
    .sysclk_i, .rst_n_i, .wr_i(rx_wr.valid), .wdata_i(rx_wr.data), .rd_i(rx_pop),
    .rdata_o(rx_head), .full_o(rx_full), .empty_o(rx_empty)
  );

  // ==============================
  // Serial engines
  // ==============================

  uart_baud_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) baud_gen_i (
    .sysclk_i, .rst_n_i, .bit_tick_o(bit_tick), .os_tick_o(os_tick)
  );

  uart_tx tx_i (
    .sysclk_i, .rst_n_i, .bit_tick_i(bit_tick), .fifo_data_i(tx_head),
    .fifo_empty_i(tx_empty), .fifo_pop_o(tx_pop), .txd_o, .idle_o(tx_idle)
  );

  uart_rx rx_i (
    .sysclk_i, .rst_n_i, .os_tick_i(os_tick), .rxd_i, .byte_o(line_byte)
  );

endmodule

// File: source/uart_pkg.sv
// Shared types and constants for the UART peripheral
// Every RTL file refers to these by scoped name, e.g. uart_pkg::byte_t
// Holds the data widths, register map, status layout and FSM encodings
package uart_pkg;

  // Data byte on any path (bus, FIFOs, serial engines, console)
  typedef logic [7:0] byte_t;

  // Register address on the strobe bus
  typedef logic [1:0] reg_addr_t;

  // Register map
  // Write pushes the TX FIFO, read pops the RX FIFO
  localparam reg_addr_t ADDR_DATA   = 2'd0;
  localparam reg_addr_t ADDR_STATUS = 2'd1;

  // Status word as seen on a read of ADDR_STATUS, padded out to one byte
  typedef struct packed {
    logic [2:0] pad;
    logic       rx_overrun;  // sticky, cleared by reading status
    logic       tx_idle;
    logic       tx_full;
    logic       rx_full;
    logic       rx_empty;
  } uart_status_t;

  // Write port of the RX FIFO, also used for a byte coming off the line
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_wr_t;

  // Transmit and receive FSMs share a shape but keep separate literals
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

// File: source/uart_reg_if.sv
// Register decoder on the plain strobe bus
// ADDR_DATA write pushes TX, ADDR_DATA read pops RX, ADDR_STATUS reads status
// Read data is registered and shows up one cycle after the read strobe
`timescale 1ns/1ps

module uart_reg_if (
  input  logic                sysclk_i,
  input  logic                rst_n_i,
  input  logic                bus_wr_i,
  input  logic                bus_rd_i,
  input  uart_pkg::reg_addr_t bus_addr_i,
  input  uart_pkg::byte_t     bus_wdata_i,
  output uart_pkg::byte_t     bus_rdata_o,
  output logic                tx_push_o,
  output uart_pkg::byte_t     tx_data_o,
  input  logic                tx_full_i,
  input  logic                tx_idle_i,
  output logic                rx_pop_o,
  input  uart_pkg::byte_t     rx_data_i,
  input  logic                rx_full_i,
  input  logic                rx_empty_i,
  input  logic                line_drop_i
);

  uart_pkg::uart_status_t status;
  logic                   rx_overrun;
  logic                   status_rd;

  // ==============================
  // Strobe decode
  // ==============================

  // Full TX drops the write, empty RX makes the read a no-op
  assign tx_push_o = bus_wr_i && (bus_addr_i == uart_pkg::ADDR_DATA) && !tx_full_i;
  assign tx_data_o = bus_wdata_i;
  assign rx_pop_o  = bus_rd_i && (bus_addr_i == uart_pkg::ADDR_DATA) && !rx_empty_i;
  assign status_rd = bus_rd_i && (bus_addr_i == uart_pkg::ADDR_STATUS);

  // ==============================
  // Status and read data
  // ==============================

  always_comb begin
    status            = '0;
    status.rx_overrun = rx_overrun;
    status.tx_idle    = tx_idle_i;
    status.tx_full    = tx_full_i;
    status.rx_full    = rx_full_i;
    status.rx_empty   = rx_empty_i;
  end

  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_overrun  <= 1'b0;
      bus_rdata_o <= '0;
    end else begin
      // A drop in the same cycle as the clearing read keeps the bit set
      if (line_drop_i) begin
        rx_overrun <= 1'b1;
      end else if (status_rd) begin
        rx_overrun <= 1'b0;
      end
      bus_rdata_o <= '0;
      if (rx_pop_o) begin
        bus_rdata_o <= rx_data_i;
      end else if (status_rd) begin
        bus_rdata_o <= uart_pkg::byte_t'(status);
      end
    end
  end

endmodule

// File: source/uart_rx.sv
// Serial receiver, 8N1 frames at sixteen times oversampling
// Confirms the start bit at mid-bit, then samples each bit at its centre
// A good frame is handed on as a one-cycle valid in the middle of the stop bit
`timescale 1ns/1ps

module uart_rx (
  input  logic             sysclk_i,
  input  logic             rst_n_i,
  input  logic             os_tick_i,
  input  logic             rxd_i,
  output uart_pkg::rx_wr_t byte_o
);

  uart_pkg::rx_state_t state;
  uart_pkg::byte_t     shift;
  logic [3:0]          os_cnt;
  logic [2:0]          bit_cnt;
  logic                rxd_meta;
  logic                rxd_sync;
  logic                frame_ok;

  // Frame is accepted when the stop bit is still high at its centre
  assign frame_ok = os_tick_i && (state == uart_pkg::RX_STOP) &&
                    (os_cnt == 4'd15) && rxd_sync;

  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Synchronizer idles at the line's resting level
      rxd_meta     <= 1'b1;
      rxd_sync     <= 1'b1;
      state        <= uart_pkg::RX_IDLE;
      os_cnt       <= '0;
      bit_cnt      <= '0;
      byte_o.valid <= 1'b0;
      byte_o.data  <= '0;
    end else begin
      rxd_meta     <= rxd_i;
      rxd_sync     <= rxd_meta;
      byte_o.valid <= frame_ok;
      if (frame_ok) begin
        byte_o.data <= shift;
      end
      if (os_tick_i) begin
        os_cnt <= os_cnt + 4'd1;
        case (state)
          uart_pkg::RX_IDLE: begin
            os_cnt <= '0;
            if (!rxd_sync) begin
              state <= uart_pkg::RX_START;
            end
          end
          uart_pkg::RX_START: begin
            if (os_cnt == 4'd7) begin
              // Still low at mid-bit, so not a glitch
              os_cnt  <= '0;
              bit_cnt <= '0;
              state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
            end
          end
          uart_pkg::RX_DATA: begin
            if (os_cnt == 4'd15 && bit_cnt == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end else if (os_cnt == 4'd15) begin
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
          default: begin
            if (os_cnt == 4'd15) begin
              state <= uart_pkg::RX_IDLE;
            end
          end
        endcase
      end
    end
  end

  // Data bits arrive LSB first and shift in from the top
  always_ff @(posedge sysclk_i) begin
    if (os_tick_i && state == uart_pkg::RX_DATA && os_cnt == 4'd15) begin
      shift <= {rxd_sync, shift[7:1]};
    end
  end

endmodule

// File: source/uart_tx.sv
// Serial transmitter, 8N1 frames
// Pops the TX FIFO on a bit tick and shifts the byte out LSB first
// idle_o is high only when no frame is running and the FIFO is drained
`timescale 1ns/1ps

module uart_tx (
  input  logic              sysclk_i,
  input  logic              rst_n_i,
  input  logic              bit_tick_i,
  input  uart_pkg::byte_t   fifo_data_i,
  input  logic              fifo_empty_i,
  output logic              fifo_pop_o,
  output logic              txd_o,
  output logic              idle_o
);

  uart_pkg::tx_state_t state;
  uart_pkg::byte_t     shift;
  logic [2:0]          bit_cnt;

  // A pop starts the start bit, and the last stop tick may chain the next frame
  assign fifo_pop_o = bit_tick_i && !fifo_empty_i &&
                      (state == uart_pkg::TX_IDLE || state == uart_pkg::TX_STOP);
  assign idle_o     = (state == uart_pkg::TX_IDLE) && fifo_empty_i;

  always_ff @(posedge sysclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state   <= uart_pkg::TX_IDLE;
      shift   <= '0;
      bit_cnt <= '0;
      txd_o   <= 1'b1;
    end else if (fifo_pop_o) begin
      // Line goes low for the start bit right on the tick
      state <= uart_pkg::TX_START;
      shift <= fifo_data_i;
      txd_o <= 1'b0;
    end else if (bit_tick_i) begin
      case (state)
        uart_pkg::TX_START: begin
          txd_o   <= shift[0];
          shift   <= shift >> 1;
          bit_cnt <= '0;
          state   <= uart_pkg::TX_DATA;
        end
        uart_pkg::TX_DATA: begin
          if (bit_cnt == 3'd7) begin
            // Eighth data bit done, drive the stop bit
            txd_o <= 1'b1;
            state <= uart_pkg::TX_STOP;
          end else begin
            txd_o   <= shift[0];
            shift   <= shift >> 1;
            bit_cnt <= bit_cnt + 3'd1;
          end
        end
        uart_pkg::TX_STOP: state <= uart_pkg::TX_IDLE;
        default: txd_o <= 1'b1;
      endcase
    end
  end

endmodule

// File: verif/uart_periph_assertions.sv
// Protocol checks for the UART peripheral
// Bound into the top level, where both FIFOs and the console tap meet
// Checks FIFO write and pop legality and that each console copy lands in the TX FIFO
`timescale 1ns/1ps

module uart_periph_assertions (
  input logic            sysclk_i,
  input logic            rst_n_i,
  input logic            tx_wr_i,
  input logic            tx_full_i,
  input logic            tx_rd_i,
  input logic            tx_empty_i,
  input uart_pkg::byte_t tx_head_i,
  input logic            rx_wr_i,
  input logic            rx_full_i,
  input logic            rx_rd_i,
  input logic            rx_empty_i,
  input logic            con_tx_wr_i,
  input uart_pkg::byte_t con_tx_data_i
);

  // ==============================
  // FIFO legality
  // ==============================

  tx_no_write_full: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
    tx_wr_i |-> !tx_full_i) else $error("TX FIFO written while full");
  tx_no_pop_empty: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
    tx_rd_i |-> !tx_empty_i) else $error("TX FIFO popped while empty");
  rx_no_write_full: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
    rx_wr_i |-> !rx_full_i) else $error("RX FIFO written while full");
  rx_no_pop_empty: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
    rx_rd_i |-> !rx_empty_i) else $error("RX FIFO popped while empty");

  // A console copy into an empty TX FIFO is the byte at its head one cycle later
  con_lands_in_fifo: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
    (con_tx_wr_i && tx_empty_i) |=> (!tx_empty_i && (tx_head_i == $past(con_tx_data_i))))
    else $error("Console copy differs from the byte stored in the TX FIFO");

endmodule

bind uart_periph uart_periph_assertions checks_i (
  .sysclk_i, .rst_n_i, .tx_wr_i(tx_push), .tx_full_i(tx_full),
  .tx_rd_i(tx_pop), .tx_empty_i(tx_empty), .tx_head_i(tx_head), .rx_wr_i(rx_wr.valid),
  .rx_full_i(rx_full), .rx_rd_i(rx_pop), .rx_empty_i(rx_empty), .con_tx_wr_i(con_tx_wr_o),
  .con_tx_data_i(con_tx_data_o)
);

// File: verif/uart_periph_tb.sv
// Testbench for the UART peripheral with console tap
// Reads commands from the stimulus file, drives the strobe bus and the console,
// loops txd_o back into rxd_i and checks read data, status and console mirror
// Run from the project root so the stimulus path resolves
`timescale 1ns/1ps

module uart_periph_tb;

  localparam int          CLKS_PER_BIT = 16;
  localparam int          FIFO_DEPTH   = 8;
  localparam int unsigned SEED         = 32'h428c32eb;
  localparam string       STIM_FILE    = "verif/uart_stimulus.txt";

  logic                sysclk = 1'b0;
  logic                rst_n;
  logic                bus_wr;
  logic                bus_rd;
  uart_pkg::reg_addr_t bus_addr;
  uart_pkg::byte_t     bus_wdata;
  uart_pkg::byte_t     bus_rdata;
  logic                serial_line;
  logic                con_tx_wr;
  uart_pkg::byte_t     con_tx_data;
  logic                con_rx_wr;
  uart_pkg::byte_t     con_rx_data;
  logic                con_rx_full;

  // Parsed commands, one entry per non-comment line of the stimulus file
  logic [7:0]      op_q[$];
  uart_pkg::byte_t arg_q[$];
  uart_pkg::byte_t exp_q[$];
  int              line_q[$];
  // Random filler bytes still waiting to be read back, oldest first
  uart_pkg::byte_t filler_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;

  // Serial line is looped back, so every transmitted byte comes back as a line byte
  uart_periph #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
    .sysclk_i(sysclk), .rst_n_i(rst_n), .bus_wr_i(bus_wr), .bus_rd_i(bus_rd),
    .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata),
    .txd_o(serial_line), .rxd_i(serial_line), .con_tx_wr_o(con_tx_wr),
    .con_tx_data_o(con_tx_data), .con_rx_wr_i(con_rx_wr), .con_rx_data_i(con_rx_data),
    .con_rx_full_o(con_rx_full)
  );

  always #5 sysclk = ~sysclk;

  // Watchdog, armed once the command count is known
  always @(posedge sysclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  // ==============================
  // Helpers
  // ==============================

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input uart_pkg::byte_t expected,
                             input uart_pkg::byte_t actual);
    assert (actual === expected) else begin
      $display("ERROR %s: expected %02h, actual %02h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Columns are op, operand and expected value, both numbers in hex
  task automatic load_commands();
    int              fd;
    int              n;
    int              line_no;
    string           text;
    uart_pkg::byte_t arg;
    uart_pkg::byte_t expv;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) fail_now({"Cannot open the stimulus file ", STIM_FILE});
    line_no = 0;
    while ($fgets(text, fd) != 0) begin
      line_no++;
      if (text.len() < 2 || text.getc(0) == "#") continue;
      n = $sscanf(text.substr(1, text.len() - 1), "%h %h", arg, expv);
      if (n != 2) fail_now($sformatf("Stimulus line %0d cannot be parsed", line_no));
      op_q.push_back(text.getc(0));
      arg_q.push_back(arg);
      exp_q.push_back(expv);
      line_q.push_back(line_no);
    end
    $fclose(fd);
  endtask

  // The console mirror is combinational, so it is checked in the write cycle itself
  task automatic write_data(input string name, input uart_pkg::byte_t data,
                            input logic accept);
    @(posedge sysclk);
    #1;
    bus_wr    = 1'b1;
    bus_addr  = uart_pkg::ADDR_DATA;
    bus_wdata = data;
    #1;
    check_value({name, "_con_tx_wr"}, 8'(accept), 8'(con_tx_wr));
    check_value({name, "_con_tx_data"}, accept ? data : 8'h00, con_tx_data);
    @(posedge sysclk);
    #1;
    bus_wr    = 1'b0;
    bus_wdata = '0;
  endtask

  // Read data is registered, so it is taken one cycle after the strobe
  task automatic read_reg(input uart_pkg::reg_addr_t addr, output uart_pkg::byte_t data);
    @(posedge sysclk);
    #1;
    bus_rd   = 1'b1;
    bus_addr = addr;
    @(posedge sysclk);
    #1;
    bus_rd = 1'b0;
    data   = bus_rdata;
  endtask

  // A byte is stored only while the RX FIFO reports room
  task automatic inject_byte(input string name, input uart_pkg::byte_t data,
                             input logic stored);
    @(posedge sysclk);
    #1;
    check_value({name, "_con_rx_full"}, 8'(!stored), 8'(con_rx_full));
    con_rx_wr   = 1'b1;
    con_rx_data = data;
    @(posedge sysclk);
    #1;
    con_rx_wr   = 1'b0;
    con_rx_data = '0;
  endtask

  task automatic fill_rx(input string name, input int count, input logic full_after);
    uart_pkg::byte_t value;
    repeat (count) begin
      value = 8'($urandom);
      filler_q.push_back(value);
      inject_byte(name, value, 1'b1);
    end
    check_value({name, "_full_after"}, 8'(full_after), 8'(con_rx_full));
  endtask

  // Polls status until a byte is waiting, then checks the status word that showed it
  task automatic poll_rx_ready(input string name, input uart_pkg::byte_t expected);
    uart_pkg::byte_t      raw;
    uart_pkg::uart_status_t st;
    do begin
      read_reg(uart_pkg::ADDR_STATUS, raw);
      st = uart_pkg::uart_status_t'(raw);
    end while (st.rx_empty);
    check_value(name, expected, raw);
  endtask

  // Watches the transmitter idle flag directly, as a status read would clear overrun
  task automatic wait_tx_idle();
    do begin
      @(posedge sysclk);
      #1;
    end while (!dut_i.tx_idle);
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    int              i;
    string           name;
    uart_pkg::byte_t arg;
    uart_pkg::byte_t expv;
    uart_pkg::byte_t got;
    void'($urandom(SEED));
    rst_n       = 1'b0;
    bus_wr      = 1'b0;
    bus_rd      = 1'b0;
    bus_addr    = '0;
    bus_wdata   = '0;
    con_rx_wr   = 1'b0;
    con_rx_data = '0;
    load_commands();
    // Twelve frames per command leaves room for a full poll behind a busy transmitter
    cycle_limit = op_q.size() * 12 * 10 * CLKS_PER_BIT;
    repeat (5) @(posedge sysclk);
    #1;
    rst_n = 1'b1;
    // Out of reset the line rests high and the console and bus outputs are quiet
    check_value("reset_txd", 8'h01, 8'(serial_line));
    check_value("reset_con_tx_wr", 8'h00, 8'(con_tx_wr));
    check_value("reset_con_tx_data", 8'h00, con_tx_data);
    check_value("reset_con_rx_full", 8'h00, 8'(con_rx_full));
    check_value("reset_bus_rdata", 8'h00, bus_rdata);
    for (i = 0; i < op_q.size(); i++) begin
      name = $sformatf("line%0d_%c", line_q[i], op_q[i]);
      arg  = arg_q[i];
      expv = exp_q[i];
      case (op_q[i])
        "W": write_data(name, arg, expv[0]);
        "R": begin
          // Operand 1 takes the expected byte from the filler queue
          if (arg == 8'h01) begin
            if (filler_q.size() == 0) begin
              fail_now({name, " reads a filler byte, none pending"});
            end else begin
              expv = filler_q.pop_front();
            end
          end
          read_reg(uart_pkg::ADDR_DATA, got);
          check_value(name, expv, got);
        end
        "S": begin
          read_reg(uart_pkg::ADDR_STATUS, got);
          check_value(name, expv, got);
        end
        "I": inject_byte(name, arg, expv[0]);
        "P": poll_rx_ready(name, expv);
        "F": fill_rx(name, int'(arg), expv[0]);
        "D": wait_tx_idle();
        default: fail_now({name, " has an unknown operation"});
      endcase
    end
    if (filler_q.size() != 0) begin
      fail_now("Some filler bytes were never read back");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: verif/uart_stimulus.txt
# Columns: op operand expected (hex). W data accept | R src(0 column, 1 filler) data
# S - status | I data stored | P - status | F count full_after | D - - (wait TX idle)
S 00 09
R 00 00
I 3C 01
I C3 01
S 00 08
R 00 3C
R 00 C3
R 00 00
F 08 01
S 00 0A
I 77 00
W 5A 01
D 00 00
S 00 1A
S 00 0A
R 01 00
R 01 00
R 01 00
R 01 00
R 01 00
R 01 00
R 01 00
R 01 00
R 00 00
S 00 09
W 11 01
W 22 01
W 33 01
P 00 00
R 00 11
P 00 00
R 00 22
P 00 00
R 00 33
S 00 09
